// ==== compile.f ====
hw/mem_layout_pkg.sv
hw/link_pkg.sv
hw/axi_transmit.sv
hw/link_receive.sv
hw/addr_translate.sv
hw/result_stage.sv
hw/link_top.sv
tb/link_tb.sv

// ==== hw/addr_translate.sv ====
module addr_translate (
	input  logic clk,
	input  logic reset,
	input  link_pkg::rx_word_u rx_word,
	input  link_pkg::word_kind_e rx_kind,
	input  logic rx_valid,
	output logic [link_pkg::DATA_WIDTH-1:0] xl_word,
	output logic xl_miss,
	output logic xl_valid
);

	logic hit;
	logic [mem_layout_pkg::REGION_IDX_BITS-1:0] region_idx;
	link_pkg::rx_word_u mapped;

	//////////////////////////////
	// region lookup

	always_comb begin
		hit = 1'b0;
		region_idx = '0;
		for (int i = 0; i < mem_layout_pkg::REGION_NUM; i++) begin
			if (!hit && rx_word.addr.region == mem_layout_pkg::region_bases[i]) begin
				hit = 1'b1;	// first matching entry wins
				region_idx = i[mem_layout_pkg::REGION_IDX_BITS-1:0];
			end
		end
	end

	always_comb begin
		mapped.addr.region = '0;
		mapped.addr.region[mem_layout_pkg::REGION_IDX_BITS-1:0] = region_idx;
		mapped.addr.offset = rx_word.addr.offset;	// offset is kept as is
	end

	//////////////////////////////
	// output register

	always_ff @(posedge clk) begin
		if (reset)
			xl_valid <= 1'b0;
		else
			xl_valid <= rx_valid;
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			if (rx_kind == link_pkg::KIND_ADDR && hit) begin
				xl_word <= mapped.raw;
				xl_miss <= 1'b0;
			end else begin
				xl_word <= rx_word.raw;	// data words and unmapped addresses pass unchanged
				xl_miss <= (rx_kind == link_pkg::KIND_ADDR);
			end
		end
	end

	// only an address word can miss the memory map
	assert property (@(posedge clk) disable iff (reset)
		xl_valid && xl_miss |-> $past(rx_kind) == link_pkg::KIND_ADDR);

endmodule

// ==== hw/axi_transmit.sv ====
module axi_transmit #(
	parameter int BUS_WIDTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic [link_pkg::DATA_WIDTH-1:0] data_to_send,
	input  link_pkg::word_kind_e kind,
	input  logic send,
	input  logic dev_rdy,
	output logic [BUS_WIDTH-1:0] bus_data,
	output logic bus_valid,
	output logic bus_first,
	output logic busy
);

	localparam int BEATS = link_pkg::DATA_WIDTH / BUS_WIDTH;
	localparam int CNT_WIDTH = $clog2(BEATS + 1);

	logic [link_pkg::DATA_WIDTH-1:0] shift_q;
	link_pkg::word_kind_e kind_q;
	logic [CNT_WIDTH-1:0] beat_cnt;	// 0 is the header and 1 to BEATS are data
	logic last_beat;

	assign bus_valid = busy && dev_rdy;	// a pending beat waits for dev_rdy
	assign bus_first = (beat_cnt == '0);
	assign last_beat = (beat_cnt == CNT_WIDTH'(BEATS));

	always_comb begin
		bus_data = shift_q[BUS_WIDTH-1:0];	// least significant beat first
		if (bus_first) begin
			bus_data = '0;
			bus_data[link_pkg::HDR_KIND_BIT] = kind_q;
		end
	end

	//////////////////////////////
	// beat sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			beat_cnt <= '0;
		end else if (!busy) begin
			if (send) begin
				busy <= 1'b1;	// sends while busy are dropped
				beat_cnt <= '0;
			end
		end else if (dev_rdy) begin
			if (last_beat) begin
				busy <= 1'b0;
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && send) begin
			shift_q <= data_to_send;
			kind_q <= kind;
		end else if (bus_valid && !bus_first) begin
			shift_q <= shift_q >> BUS_WIDTH;
		end
	end

	// nothing leaves while the device is not ready, so the pending beat keeps its data
	assert property (@(posedge clk) disable iff (reset) busy && !dev_rdy |=> $stable(shift_q));

	// a stalled beat is held until it can go out
	assert property (@(posedge clk) disable iff (reset)
		busy && !dev_rdy |=> busy && beat_cnt == $past(beat_cnt));

endmodule

// ==== hw/link_pkg.sv ====
package link_pkg;

	localparam int DATA_WIDTH = 32;

	//////////////////////////////
	// header beat

	typedef enum logic {
		KIND_DATA = 1'b0,
		KIND_ADDR = 1'b1
	} word_kind_e;

	localparam int HDR_KIND_BIT = 0;	// the other header bits are sent as zero

	//////////////////////////////
	// received word

	// the same word seen as plain data or as a region and offset pair
	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		struct packed {
			logic [mem_layout_pkg::REGION_BITS-1:0] region;
			logic [mem_layout_pkg::OFFSET_BITS-1:0] offset;
		} addr;
	} rx_word_u;

endpackage

// ==== hw/link_receive.sv ====
module link_receive #(
	parameter int BUS_WIDTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic [BUS_WIDTH-1:0] bus_data,
	input  logic bus_valid,
	input  logic bus_first,
	output link_pkg::rx_word_u rx_word,
	output link_pkg::word_kind_e rx_kind,
	output logic rx_valid
);

	localparam int BEATS = link_pkg::DATA_WIDTH / BUS_WIDTH;
	localparam int CNT_WIDTH = $clog2(BEATS + 1);

	logic [link_pkg::DATA_WIDTH-1:0] shift_q;
	link_pkg::word_kind_e kind_q;
	logic [CNT_WIDTH-1:0] beat_cnt;
	logic in_word;	// set between a header and the last data beat
	logic header_beat;
	logic data_beat;

	assign header_beat = bus_valid && bus_first;
	assign data_beat = bus_valid && !bus_first && in_word;

	assign rx_word.raw = shift_q;
	assign rx_kind = kind_q;

	//////////////////////////////
	// word framing

	always_ff @(posedge clk) begin
		if (reset) begin
			in_word <= 1'b0;
			beat_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (header_beat) begin
				in_word <= 1'b1;
				beat_cnt <= '0;
			end else if (data_beat) begin
				if (beat_cnt == CNT_WIDTH'(BEATS - 1)) begin
					in_word <= 1'b0;
					beat_cnt <= '0;
					rx_valid <= 1'b1;	// word is complete in shift_q next cycle
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (header_beat)
			kind_q <= link_pkg::word_kind_e'(bus_data[link_pkg::HDR_KIND_BIT]);
		if (data_beat)
			shift_q <= {bus_data, shift_q[link_pkg::DATA_WIDTH-1:BUS_WIDTH]};	// first beat ends lowest
	end

	// the transmitter finishes a word before it starts the next one
	assert property (@(posedge clk) disable iff (reset) header_beat |-> !in_word);

endmodule

// ==== hw/link_top.sv ====
module link_top #(
	parameter int BUS_WIDTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic [link_pkg::DATA_WIDTH-1:0] data_to_send,
	input  logic send,
	input  link_pkg::word_kind_e kind,
	input  logic dev_rdy,
	output logic [link_pkg::DATA_WIDTH-1:0] data,
	output logic valid_data,
	output logic addr_miss,
	output logic busy,
	output logic [15:0] word_count
);

	logic [BUS_WIDTH-1:0] bus_data;
	logic bus_valid;
	logic bus_first;

	link_pkg::rx_word_u rx_word;
	link_pkg::word_kind_e rx_kind;
	logic rx_valid;

	logic [link_pkg::DATA_WIDTH-1:0] xl_word;
	logic xl_miss;
	logic xl_valid;

	//////////////////////////////
	// transmit side

	axi_transmit #(
		.BUS_WIDTH(BUS_WIDTH)
	) transmitter (
		.clk(clk),
		.reset(reset),
		.data_to_send(data_to_send),
		.kind(kind),
		.send(send),
		.dev_rdy(dev_rdy),
		.bus_data(bus_data),
		.bus_valid(bus_valid),
		.bus_first(bus_first),
		.busy(busy)
	);

	//////////////////////////////
	// receive side

	link_receive #(
		.BUS_WIDTH(BUS_WIDTH)
	) receiver (
		.clk(clk),
		.reset(reset),
		.bus_data(bus_data),
		.bus_valid(bus_valid),
		.bus_first(bus_first),
		.rx_word(rx_word),
		.rx_kind(rx_kind),
		.rx_valid(rx_valid)
	);

	addr_translate translator (
		.clk(clk),
		.reset(reset),
		.rx_word(rx_word),
		.rx_kind(rx_kind),
		.rx_valid(rx_valid),
		.xl_word(xl_word),
		.xl_miss(xl_miss),
		.xl_valid(xl_valid)
	);

	result_stage result (
		.clk(clk),
		.reset(reset),
		.xl_word(xl_word),
		.xl_miss(xl_miss),
		.xl_valid(xl_valid),
		.data(data),
		.valid_data(valid_data),
		.addr_miss(addr_miss),
		.word_count(word_count)
	);

endmodule

// ==== hw/mem_layout_pkg.sv ====
package mem_layout_pkg;

	//////////////////////////////
	// address split

	// an address word is a region field on top of an offset field
	localparam int REGION_BITS = 8;
	localparam int OFFSET_BITS = 24;	// 16 MiB behind each region

	//////////////////////////////
	// region map

	localparam int REGION_NUM = 8;
	localparam int REGION_IDX_BITS = $clog2(REGION_NUM);	// width of a region id

	// region field value of each mapped region
	// the position of an entry in this table is the id of its region
	localparam logic [REGION_BITS-1:0] region_bases [REGION_NUM] = '{
		8'h00,	// boot rom
		8'h10,	// on-chip sram
		8'h20,	// dma descriptors
		8'h40,	// peripheral registers
		8'h80,	// external dram low
		8'ha0,	// external dram high
		8'hc0,	// frame buffer
		8'hf0	// debug window
	};

endpackage

// ==== hw/result_stage.sv ====
module result_stage (
	input  logic clk,
	input  logic reset,
	input  logic [link_pkg::DATA_WIDTH-1:0] xl_word,
	input  logic xl_miss,
	input  logic xl_valid,
	output logic [link_pkg::DATA_WIDTH-1:0] data,
	output logic valid_data,
	output logic addr_miss,
	output logic [15:0] word_count
);

	//////////////////////////////
	// delivery and statistics

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_data <= 1'b0;
			word_count <= '0;
		end else begin
			valid_data <= xl_valid;
			if (xl_valid)
				word_count <= word_count + 16'd1;	// wraps after 65535 words
		end
	end

	// word and miss flag hold until the next delivered word
	always_ff @(posedge clk) begin
		if (xl_valid) begin
			data <= xl_word;
			addr_miss <= xl_miss;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the link testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f compile.f --top-module link_tb \
	-Mdir obj_dir -o link_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/link_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

// ==== tb/link_tb.sv ====
module link_tb;

	localparam int BUS_WIDTH = 8;
	localparam int BEATS = link_pkg::DATA_WIDTH / BUS_WIDTH;
	localparam int MAX_RECS = 64;
	localparam int TIMEOUT = 200;	// cycles any single wait may take

	typedef struct {
		link_pkg::word_kind_e kind;
		logic [link_pkg::DATA_WIDTH-1:0] word_in;
		logic [link_pkg::DATA_WIDTH-1:0] word_exp;
		logic miss_exp;
	} test_rec_t;

	logic clk;
	logic reset;
	logic [link_pkg::DATA_WIDTH-1:0] data_to_send;
	logic send;
	link_pkg::word_kind_e kind;
	logic dev_rdy;
	logic [link_pkg::DATA_WIDTH-1:0] data;
	logic valid_data;
	logic addr_miss;
	logic busy;
	logic [15:0] word_count;

	logic [link_pkg::DATA_WIDTH-1:0] raw [4*MAX_RECS];	// four columns per record
	test_rec_t recs [MAX_RECS];
	int num_recs;
	int sent_count;
	int errors;
	int tests_run;
	int tests_failed;
	bit aborted;
	bit stream_done;
	logic [31:0] lfsr_state;

	link_top #(
		.BUS_WIDTH(BUS_WIDTH)
	) uut (
		.clk(clk),
		.reset(reset),
		.data_to_send(data_to_send),
		.send(send),
		.kind(kind),
		.dev_rdy(dev_rdy),
		.data(data),
		.valid_data(valid_data),
		.addr_miss(addr_miss),
		.busy(busy),
		.word_count(word_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// random stalls

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	task automatic take_random_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	//////////////////////////////
	// compare tasks

	task automatic compare_word(input string name, input logic [link_pkg::DATA_WIDTH-1:0] exp,
			input logic [link_pkg::DATA_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: data expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: flag expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_count(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: word_count expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %s: latency expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		tests_run++;
		if (errors == first_err) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d error(s)", name, errors - first_err);
		end
	endtask

	//////////////////////////////
	// waits and driving

	task automatic wait_idle(input string name, output bit ok);
		int cycles;
		cycles = 0;
		while (busy && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		ok = !busy;
		if (!ok) begin
			$display("%s: busy stayed high for %0d cycles", name, TIMEOUT);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_valid(input string name, output int cycles, output bit ok);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!valid_data && cycles < TIMEOUT);
		ok = valid_data;
		if (!ok) begin
			$display("%s: valid_data never came within %0d cycles", name, TIMEOUT);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic send_word(input test_rec_t r);
		data_to_send = r.word_in;
		kind = r.kind;
		send = 1'b1;
		@(negedge clk);
		send = 1'b0;
		sent_count++;
	endtask

	//////////////////////////////
	// tests

	task automatic run_single(input int idx);
		string name;
		int cycles;
		int first_err;
		bit ok;
		name = $sformatf("rec %0d", idx);
		first_err = errors;
		wait_idle(name, ok);
		if (ok) begin
			send_word(recs[idx]);
			wait_valid(name, cycles, ok);
		end
		if (ok) begin
			compare_latency(name, BEATS + 4, cycles + 1);	// the send cycle counts too
			compare_word(name, recs[idx].word_exp, data);
			compare_flag(name, recs[idx].miss_exp, addr_miss);
			compare_count(name, 16'(sent_count), word_count);
		end
		report_test(name, first_err);
	endtask

	task automatic run_stream(input string name, input bit stall);
		int first_err;
		first_err = errors;
		stream_done = 1'b0;
		fork
			begin
				bit ok;
				for (int i = 0; i < num_recs && !aborted; i++) begin
					wait_idle(name, ok);
					if (ok)
						send_word(recs[i]);	// goes out as soon as busy falls
				end
			end
			begin
				int cycles;
				bit ok;
				string rec_name;
				for (int i = 0; i < num_recs && !aborted; i++) begin
					rec_name = $sformatf("%s rec %0d", name, i);
					wait_valid(rec_name, cycles, ok);
					if (ok) begin
						compare_word(rec_name, recs[i].word_exp, data);
						compare_flag(rec_name, recs[i].miss_exp, addr_miss);
					end
				end
				stream_done = 1'b1;
			end
			begin
				logic b1;
				logic b2;
				while (stall && !stream_done) begin
					@(negedge clk);
					take_random_bit(b1);
					take_random_bit(b2);
					dev_rdy = b1 | b2;	// ready three cycles out of four
				end
				dev_rdy = 1'b1;
			end
		join
		compare_count(name, 16'(sent_count), word_count);
		report_test(name, first_err);
	endtask

	task automatic run_busy_ignore(input int idx);
		string name;
		int cycles;
		int extra;
		int first_err;
		bit ok;
		name = "send while busy";
		first_err = errors;
		wait_idle(name, ok);
		if (ok) begin
			data_to_send = recs[idx].word_in;
			kind = recs[idx].kind;
			send = 1'b1;
			sent_count++;
			for (int k = 1; k <= BEATS; k++) begin
				@(negedge clk);
				data_to_send = ~recs[idx].word_in;
				send = (k % 2 == 1) && busy;
			end
			@(negedge clk);
			send = 1'b0;
			wait_valid(name, cycles, ok);
		end
		if (ok) begin
			compare_word(name, recs[idx].word_exp, data);
			compare_flag(name, recs[idx].miss_exp, addr_miss);
			extra = 0;
			repeat (3 * (BEATS + 4)) begin
				@(negedge clk);
				if (valid_data)
					extra++;
			end
			if (extra != 0) begin
				$display("%s: sends made while busy produced %0d extra word(s)", name, extra);
				errors++;
			end
			compare_count(name, 16'(sent_count), word_count);
		end
		report_test(name, first_err);
	endtask

	//////////////////////////////
	// main sequence

	initial begin
		reset = 1'b1;
		send = 1'b0;
		data_to_send = '0;
		kind = link_pkg::KIND_DATA;
		dev_rdy = 1'b1;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		sent_count = 0;
		aborted = 1'b0;
		stream_done = 1'b0;
		lfsr_state = 32'h9e9c;

		for (int i = 0; i < 4 * MAX_RECS; i++)
			raw[i] = '1;	// a kind column of all ones ends the record list
		$readmemh("tb/link_testdata.mem", raw);
		num_recs = 0;
		while (num_recs < MAX_RECS && (raw[4*num_recs] === 32'h0 || raw[4*num_recs] === 32'h1)) begin
			recs[num_recs].kind = link_pkg::word_kind_e'(raw[4*num_recs][0]);
			recs[num_recs].word_in = raw[4*num_recs+1];
			recs[num_recs].word_exp = raw[4*num_recs+2];
			recs[num_recs].miss_exp = raw[4*num_recs+3][0];
			num_recs++;
		end
		if (num_recs == 0) begin
			$display("no test records could be read from tb/link_testdata.mem");
			errors++;
		end

		repeat (3) @(negedge clk);
		reset = 1'b0;
		compare_flag("after reset busy", 1'b0, busy);
		compare_flag("after reset valid_data", 1'b0, valid_data);
		compare_count("after reset", 16'd0, word_count);

		for (int i = 0; i < num_recs && !aborted; i++)
			run_single(i);
		if (!aborted)
			run_stream("stall stream", 1'b1);
		if (!aborted && num_recs > 0)
			run_busy_ignore(0);
		if (!aborted)
			run_stream("back-to-back", 1'b0);

		$display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tb/link_testdata.mem ====
// columns: kind (0 data, 1 address), input word, expected output word, expected miss
// region ids follow the order of region_bases: 00 10 20 40 80 a0 c0 f0
0 deadbeef deadbeef 0
0 00000000 00000000 0
0 ffffffff ffffffff 0
0 12345678 12345678 0
0 a5a55a5a a5a55a5a 0
0 10000000 10000000 0
// mapped addresses
1 00000000 00000000 0
1 00abcdef 00abcdef 0
1 10001234 01001234 0
1 20ffffff 02ffffff 0
1 40000010 03000010 0
1 80123456 04123456 0
1 a0000001 05000001 0
1 c0fedcba 06fedcba 0
1 f0555555 07555555 0
// addresses outside every region
1 01000000 01000000 1
1 30abcdef 30abcdef 1
1 7f000000 7f000000 1
1 ff123456 ff123456 1
1 11000000 11000000 1
// data words whose top byte matches a region
0 c0fedcba c0fedcba 0
0 0badf00d 0badf00d 0
0 f0000001 f0000001 0
1 a0ffffff 05ffffff 0
